// File: writeResponsePkg.sv
//////////////////////////////
// Write response interconnect
// Port counts, widths and shared types
//////////////////////////////
package writeResponsePkg;

    // Port counts
    localparam int numSlaves  = 4;
    localparam int numMasters = 2;

    // Widths; the slave ID carries one extra routing bit on top
    localparam int masterIdWidth = 4;
    localparam int slaveIdWidth  = masterIdWidth + 1;
    localparam int respWidth     = 2;

    typedef logic [masterIdWidth-1:0] masterId_t;
    typedef logic [slaveIdWidth-1:0]  slaveId_t;
    typedef logic [respWidth-1:0]     resp_t;

    // One-hot, zero means no grant
    typedef logic [numSlaves-1:0] grant_t;

    // Idle states name the slave with first priority
    typedef enum logic [7:0]
    {
        idlePri0 = 8'b0000_0001,
        idlePri1 = 8'b0000_0010,
        idlePri2 = 8'b0000_0100,
        idlePri3 = 8'b0000_1000,
        waitAck0 = 8'b0001_0000,
        waitAck1 = 8'b0010_0000,
        waitAck2 = 8'b0100_0000,
        waitAck3 = 8'b1000_0000
    } arbState_t;

endpackage

// File: responseIf.sv
//////////////////////////////
// Write response bundle
// Valid, ID, response and ready, ID type set per side
//////////////////////////////
`timescale 1ns/1ps

interface responseIf
#(
    parameter type idType = writeResponsePkg::slaveId_t
);

    logic                    valid;
    idType                   id;
    writeResponsePkg::resp_t resp;
    logic                    ready;

    // Side that offers the response
    modport source
    (
        output valid,
        output id,
        output resp,
        input  ready
    );

    // Side that takes it
    modport sink
    (
        input  valid,
        input  id,
        input  resp,
        output ready
    );

endinterface

// File: responseArbiter.sv
//////////////////////////////
// Round robin arbiter
// Grants one pending slave and holds it until the master ack
//////////////////////////////
`timescale 1ns/1ps

module responseArbiter
(
    input  logic                     clock,
    input  logic                     resetn,
    responseIf.sink                  slaves [writeResponsePkg::numSlaves],
    input  logic                     responseDone,
    output writeResponsePkg::grant_t grant,
    output logic                     grantStart
);

    writeResponsePkg::arbState_t           state;
    writeResponsePkg::arbState_t           nextState;
    logic [writeResponsePkg::numSlaves-1:0] pending;
    logic                                  waiting;
    logic                                  found;
    int                                    stateSlave;
    int                                    servedSlave;

    function automatic writeResponsePkg::arbState_t idleState(input int slave);
        case (slave)
            0:       return writeResponsePkg::idlePri0;
            1:       return writeResponsePkg::idlePri1;
            2:       return writeResponsePkg::idlePri2;
            default: return writeResponsePkg::idlePri3;
        endcase
    endfunction

    function automatic writeResponsePkg::arbState_t waitState(input int slave);
        case (slave)
            0:       return writeResponsePkg::waitAck0;
            1:       return writeResponsePkg::waitAck1;
            2:       return writeResponsePkg::waitAck2;
            default: return writeResponsePkg::waitAck3;
        endcase
    endfunction

    // A slave being acked this cycle is not pending
    for (genvar i = 0; i < writeResponsePkg::numSlaves; i++)
    begin : genPending
        assign pending[i] = slaves[i].valid & ~slaves[i].ready;
    end

    // Slave the state refers to
    always_comb
    begin
        waiting    = 1'b0;
        stateSlave = 0;
        case (state)
            writeResponsePkg::idlePri1: stateSlave = 1;
            writeResponsePkg::idlePri2: stateSlave = 2;
            writeResponsePkg::idlePri3: stateSlave = 3;
            writeResponsePkg::waitAck0:
            begin
                waiting    = 1'b1;
                stateSlave = 0;
            end
            writeResponsePkg::waitAck1:
            begin
                waiting    = 1'b1;
                stateSlave = 1;
            end
            writeResponsePkg::waitAck2:
            begin
                waiting    = 1'b1;
                stateSlave = 2;
            end
            writeResponsePkg::waitAck3:
            begin
                waiting    = 1'b1;
                stateSlave = 3;
            end
            default: stateSlave = 0;
        endcase
    end

    // Scan from first priority, wrapping around
    always_comb
    begin
        found       = 1'b0;
        servedSlave = stateSlave;
        if (!waiting)
        begin
            for (int offset = 0; offset < writeResponsePkg::numSlaves; offset++)
            begin
                if (!found && pending[(stateSlave + offset) % writeResponsePkg::numSlaves])
                begin
                    found       = 1'b1;
                    servedSlave = (stateSlave + offset) % writeResponsePkg::numSlaves;
                end
            end
        end
    end

    always_comb
    begin
        nextState  = state;
        grant      = '0;
        grantStart = 1'b0;
        if (waiting)
        begin
            grant[stateSlave] = 1'b1;
            // Next slave gets first priority after the ack
            if (responseDone)
                nextState = idleState((stateSlave + 1) % writeResponsePkg::numSlaves);
        end
        else if (found)
        begin
            grant[servedSlave] = 1'b1;
            grantStart         = 1'b1;
            nextState          = waitState(servedSlave);
        end
    end

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            state <= writeResponsePkg::idlePri0;
        else
            state <= nextState;
    end

endmodule

// File: responseCapture.sv
//////////////////////////////
// Response capture
// Registers the granted slave's ID and response
//////////////////////////////
`timescale 1ns/1ps

module responseCapture
(
    input  logic                       clock,
    input  logic                       resetn,
    responseIf.sink                    slaves [writeResponsePkg::numSlaves],
    input  writeResponsePkg::grant_t   grant,
    input  logic                       grantStart,
    output writeResponsePkg::slaveId_t capturedId,
    output writeResponsePkg::resp_t    capturedResp
);

    writeResponsePkg::slaveId_t slaveId   [writeResponsePkg::numSlaves];
    writeResponsePkg::resp_t    slaveResp [writeResponsePkg::numSlaves];
    writeResponsePkg::slaveId_t selectedId;
    writeResponsePkg::resp_t    selectedResp;

    for (genvar i = 0; i < writeResponsePkg::numSlaves; i++)
    begin : genUnpack
        assign slaveId[i]   = slaves[i].id;
        assign slaveResp[i] = slaves[i].resp;
    end

    // AND-OR select on the one-hot grant
    always_comb
    begin
        selectedId   = '0;
        selectedResp = '0;
        for (int i = 0; i < writeResponsePkg::numSlaves; i++)
        begin
            if (grant[i])
            begin
                selectedId   = selectedId | slaveId[i];
                selectedResp = selectedResp | slaveResp[i];
            end
        end
    end

    // Held until the next grant starts
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            capturedId   <= '0;
            capturedResp <= '0;
        end
        else if (grantStart)
        begin
            capturedId   <= selectedId;
            capturedResp <= selectedResp;
        end
    end

endmodule

// File: responseDelivery.sv
//////////////////////////////
// Response delivery
// Routes to a master and acks the granted slave
//////////////////////////////
`timescale 1ns/1ps

module responseDelivery
(
    input  logic                       clock,
    input  logic                       resetn,
    input  writeResponsePkg::grant_t   grant,
    input  logic                       grantStart,
    input  writeResponsePkg::slaveId_t capturedId,
    input  writeResponsePkg::resp_t    capturedResp,
    responseIf.source                  masters [writeResponsePkg::numMasters],
    responseIf.sink                    slaves [writeResponsePkg::numSlaves],
    output logic                       responseDone
);

    logic                                    delivering;
    logic                                    routeBit;
    logic [writeResponsePkg::numMasters-1:0] masterValid;
    logic [writeResponsePkg::numMasters-1:0] masterReady;
    writeResponsePkg::grant_t                slaveReady;

    //////////////////////////////
    // Master side
    //////////////////////////////

    // Routing bit sits in the captured ID, loaded with the start
    assign routeBit = capturedId[writeResponsePkg::slaveIdWidth-1];

    // Set one cycle after the start, cleared by the handshake
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            delivering <= 1'b0;
        else if (grantStart)
            delivering <= 1'b1;
        else if (responseDone)
            delivering <= 1'b0;
    end

    for (genvar m = 0; m < writeResponsePkg::numMasters; m++)
    begin : genMaster
        assign masterValid[m] = delivering & (routeBit == 1'(m));
        assign masterReady[m] = masters[m].ready;
        assign masters[m].valid = masterValid[m];
        // Shared ID and response bus without the routing bit
        assign masters[m].id   = capturedId[writeResponsePkg::masterIdWidth-1:0];
        assign masters[m].resp = capturedResp;
    end

    assign responseDone = |(masterValid & masterReady);

    //////////////////////////////
    // Slave side
    //////////////////////////////

    // One-cycle ack to the slave still granted at the handshake
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
            slaveReady <= '0;
        else if (responseDone)
            slaveReady <= grant;
        else
            slaveReady <= '0;
    end

    for (genvar i = 0; i < writeResponsePkg::numSlaves; i++)
    begin : genSlaveReady
        assign slaves[i].ready = slaveReady[i];
    end

endmodule

// File: writeResponseInterconnect.sv
//////////////////////////////
// Write response interconnect top
// Four slaves arbitrated onto two masters
//////////////////////////////
`timescale 1ns/1ps

module writeResponseInterconnect
(
    input  logic                        clock,
    input  logic                        resetn,

    // Slave ports
    input  logic                        slaveValid0,
    input  writeResponsePkg::slaveId_t  slaveId0,
    input  writeResponsePkg::resp_t     slaveResp0,
    output logic                        slaveReady0,
    input  logic                        slaveValid1,
    input  writeResponsePkg::slaveId_t  slaveId1,
    input  writeResponsePkg::resp_t     slaveResp1,
    output logic                        slaveReady1,
    input  logic                        slaveValid2,
    input  writeResponsePkg::slaveId_t  slaveId2,
    input  writeResponsePkg::resp_t     slaveResp2,
    output logic                        slaveReady2,
    input  logic                        slaveValid3,
    input  writeResponsePkg::slaveId_t  slaveId3,
    input  writeResponsePkg::resp_t     slaveResp3,
    output logic                        slaveReady3,

    // Master ports
    output logic                        masterValid0,
    output writeResponsePkg::masterId_t masterId0,
    output writeResponsePkg::resp_t     masterResp0,
    input  logic                        masterReady0,
    output logic                        masterValid1,
    output writeResponsePkg::masterId_t masterId1,
    output writeResponsePkg::resp_t     masterResp1,
    input  logic                        masterReady1
);

    writeResponsePkg::grant_t   grant;
    logic                       grantStart;
    logic                       responseDone;
    writeResponsePkg::slaveId_t capturedId;
    writeResponsePkg::resp_t    capturedResp;

    responseIf #(.idType(writeResponsePkg::slaveId_t))
        slaveBus [writeResponsePkg::numSlaves] ();
    responseIf #(.idType(writeResponsePkg::masterId_t))
        masterBus [writeResponsePkg::numMasters] ();

    //////////////////////////////
    // Slave pins
    //////////////////////////////
    assign slaveBus[0].valid = slaveValid0;
    assign slaveBus[0].id    = slaveId0;
    assign slaveBus[0].resp  = slaveResp0;
    assign slaveReady0       = slaveBus[0].ready;

    assign slaveBus[1].valid = slaveValid1;
    assign slaveBus[1].id    = slaveId1;
    assign slaveBus[1].resp  = slaveResp1;
    assign slaveReady1       = slaveBus[1].ready;

    assign slaveBus[2].valid = slaveValid2;
    assign slaveBus[2].id    = slaveId2;
    assign slaveBus[2].resp  = slaveResp2;
    assign slaveReady2       = slaveBus[2].ready;

    assign slaveBus[3].valid = slaveValid3;
    assign slaveBus[3].id    = slaveId3;
    assign slaveBus[3].resp  = slaveResp3;
    assign slaveReady3       = slaveBus[3].ready;

    //////////////////////////////
    // Master pins
    //////////////////////////////
    assign masterValid0       = masterBus[0].valid;
    assign masterId0          = masterBus[0].id;
    assign masterResp0        = masterBus[0].resp;
    assign masterBus[0].ready = masterReady0;

    assign masterValid1       = masterBus[1].valid;
    assign masterId1          = masterBus[1].id;
    assign masterResp1        = masterBus[1].resp;
    assign masterBus[1].ready = masterReady1;

    //////////////////////////////
    // Datapath
    //////////////////////////////
    responseArbiter arbiter
    (
        .clock        (clock),
        .resetn       (resetn),
        .slaves       (slaveBus),
        .responseDone (responseDone),
        .grant        (grant),
        .grantStart   (grantStart)
    );

    responseCapture capture
    (
        .clock        (clock),
        .resetn       (resetn),
        .slaves       (slaveBus),
        .grant        (grant),
        .grantStart   (grantStart),
        .capturedId   (capturedId),
        .capturedResp (capturedResp)
    );

    responseDelivery delivery
    (
        .clock        (clock),
        .resetn       (resetn),
        .grant        (grant),
        .grantStart   (grantStart),
        .capturedId   (capturedId),
        .capturedResp (capturedResp),
        .masters      (masterBus),
        .slaves       (slaveBus),
        .responseDone (responseDone)
    );

endmodule

// File: writeResponseTb.sv
//////////////////////////////
// Write response interconnect testbench
// Random slaves and masters against a reference model
//////////////////////////////
`timescale 1ns/1ps

module writeResponseTb;

    localparam int perSlave     = 100;
    localparam int numResponses = perSlave * writeResponsePkg::numSlaves;
    // Fifty cycles per response against about four needed
    localparam int maxCycles    = numResponses * 50;

    logic                        clock;
    logic                        resetn;
    logic [3:0]                  slaveValid;
    logic [3:0]                  slaveReady;
    writeResponsePkg::slaveId_t  slaveId [4];
    writeResponsePkg::resp_t     slaveResp [4];
    logic [1:0]                  masterValid;
    logic [1:0]                  masterReady;
    writeResponsePkg::masterId_t masterId [2];
    writeResponsePkg::resp_t     masterResp [2];

    // Slave queues with the head at the response on offer
    writeResponsePkg::slaveId_t  idMem [4][perSlave];
    writeResponsePkg::resp_t     respMem [4][perSlave];
    int                          head [4];
    logic [31:0]                 rngState;

    // Reference model state
    logic                        delivering;
    logic                        ackDue;
    int                          ackSlave;
    int                          servedSlave;
    int                          expMaster;
    writeResponsePkg::masterId_t expId;
    writeResponsePkg::resp_t     expResp;
    int                          priorityPointer;
    logic [3:0]                  pendingSet;
    logic [3:0]                  expectedReady;
    logic [3:0]                  orderedReady;
    logic [1:0]                  expectedValid;
    int                          servedCount [4];
    int                          deliveredCount;
    int                          ackedCount;
    int                          cycleCount;
    int                          errorCount;

    writeResponseInterconnect DUT
    (
        .clock        (clock),
        .resetn       (resetn),
        .slaveValid0  (slaveValid[0]),
        .slaveId0     (slaveId[0]),
        .slaveResp0   (slaveResp[0]),
        .slaveReady0  (slaveReady[0]),
        .slaveValid1  (slaveValid[1]),
        .slaveId1     (slaveId[1]),
        .slaveResp1   (slaveResp[1]),
        .slaveReady1  (slaveReady[1]),
        .slaveValid2  (slaveValid[2]),
        .slaveId2     (slaveId[2]),
        .slaveResp2   (slaveResp[2]),
        .slaveReady2  (slaveReady[2]),
        .slaveValid3  (slaveValid[3]),
        .slaveId3     (slaveId[3]),
        .slaveResp3   (slaveResp[3]),
        .slaveReady3  (slaveReady[3]),
        .masterValid0 (masterValid[0]),
        .masterId0    (masterId[0]),
        .masterResp0  (masterResp[0]),
        .masterReady0 (masterReady[0]),
        .masterValid1 (masterValid[1]),
        .masterId1    (masterId[1]),
        .masterResp1  (masterResp[1]),
        .masterReady1 (masterReady[1])
    );

    always #10 clock = ~clock;

    //////////////////////////////
    // Helpers and reference functions
    //////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // First pending slave from the pointer onward with wrap
    function automatic int nextGrant(input logic [3:0] pending, input int pointer);
        int candidate;
        for (int k = 0; k < writeResponsePkg::numSlaves; k++)
        begin
            candidate = (pointer + k) % writeResponsePkg::numSlaves;
            if (pending[candidate])
                return candidate;
        end
        return -1;
    endfunction

    // Top ID bit picks the master, the rest is the master ID
    function automatic int expectedRoute(input writeResponsePkg::slaveId_t id,
                                         output writeResponsePkg::masterId_t sideId);
        sideId = id[writeResponsePkg::masterIdWidth-1:0];
        return id[writeResponsePkg::slaveIdWidth-1] ? 1 : 0;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        errorCount++;
    endtask

    // Pop on ack, then offer the next response or leave a gap
    task automatic driveSlaves();
        for (int i = 0; i < 4; i++)
        begin
            if (slaveValid[i] && slaveReady[i])
            begin
                head[i]++;
                ackedCount++;
                slaveValid[i] = 1'b0;
            end
            if (!slaveValid[i] && head[i] < perSlave)
            begin
                rngState = xorshift(rngState);
                if (rngState[1:0] != 2'b00)
                begin
                    slaveValid[i] = 1'b1;
                    slaveId[i]    = idMem[i][head[i]];
                    slaveResp[i]  = respMem[i][head[i]];
                end
            end
        end
    endtask

    task automatic driveMasters();
        for (int m = 0; m < 2; m++)
        begin
            rngState       = xorshift(rngState);
            masterReady[m] = (rngState[2:0] > 3'd2);
        end
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////
    always @(posedge clock)
    begin
        if (resetn)
        begin
            cycleCount++;
            expectedReady = ackDue ? 4'(1 << ackSlave) : 4'b0000;
            if (slaveReady !== expectedReady)
                reportMismatch("slaveReady", 32'(expectedReady), 32'(slaveReady));
            // All four start pending, so the first four acks go in slave order
            if (ackDue && deliveredCount <= 4)
            begin
                orderedReady = 4'(1 << (deliveredCount - 1));
                if (slaveReady !== orderedReady)
                    reportMismatch("first acks slaveReady", 32'(orderedReady),
                                   32'(slaveReady));
            end
            expectedValid = delivering ? 2'(1 << expMaster) : 2'b00;
            if (masterValid !== expectedValid)
                reportMismatch("masterValid", 32'(expectedValid), 32'(masterValid));
            if (delivering && masterId[expMaster] !== expId)
                reportMismatch("masterId", 32'(expId), 32'(masterId[expMaster]));
            if (delivering && masterResp[expMaster] !== expResp)
                reportMismatch("masterResp", 32'(expResp), 32'(masterResp[expMaster]));

            // Advance the model to the next cycle
            ackDue     = 1'b0;
            pendingSet = slaveValid & ~slaveReady;
            if (delivering)
            begin
                if (masterReady[expMaster])
                begin
                    ackDue     = 1'b1;
                    ackSlave   = servedSlave;
                    delivering = 1'b0;
                    servedCount[servedSlave]++;
                    deliveredCount++;
                end
            end
            else if (pendingSet != 4'b0000)
            begin
                servedSlave     = nextGrant(pendingSet, priorityPointer);
                expMaster       = expectedRoute(slaveId[servedSlave], expId);
                expResp         = slaveResp[servedSlave];
                priorityPointer = (servedSlave + 1) % writeResponsePkg::numSlaves;
                delivering      = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Stimulus and result
    //////////////////////////////
    initial
    begin
        clock           = 1'b0;
        resetn          = 1'b0;
        rngState        = 32'h6c730e7a;
        masterReady     = 2'b00;
        delivering      = 1'b0;
        ackDue          = 1'b0;
        ackSlave        = 0;
        servedSlave     = 0;
        expMaster       = 0;
        expId           = '0;
        expResp         = '0;
        priorityPointer = 0;
        deliveredCount  = 0;
        ackedCount      = 0;
        cycleCount      = 0;
        errorCount      = 0;
        for (int i = 0; i < 4; i++)
        begin
            head[i]        = 0;
            servedCount[i] = 0;
            for (int j = 0; j < perSlave; j++)
            begin
                rngState      = xorshift(rngState);
                idMem[i][j]   = rngState[4:0];
                respMem[i][j] = rngState[9:8];
            end
            // Every slave offers its first response out of reset
            slaveValid[i] = 1'b1;
            slaveId[i]    = idMem[i][0];
            slaveResp[i]  = respMem[i][0];
        end

        repeat (3) @(posedge clock);
        @(negedge clock);
        if (masterValid !== 2'b00)
            reportMismatch("masterValid in reset", 32'h0, 32'(masterValid));
        if (slaveReady !== 4'b0000)
            reportMismatch("slaveReady in reset", 32'h0, 32'(slaveReady));
        resetn = 1'b1;

        while (ackedCount < numResponses && cycleCount < maxCycles)
        begin
            @(negedge clock);
            driveSlaves();
            driveMasters();
        end
        repeat (4) @(negedge clock);

        if (cycleCount >= maxCycles)
        begin
            $display("Timeout after %0d cycles with %0d of %0d responses acknowledged",
                     cycleCount, ackedCount, numResponses);
            errorCount++;
        end
        if (deliveredCount != numResponses)
            reportMismatch("deliveredCount", 32'(numResponses), 32'(deliveredCount));
        for (int i = 0; i < 4; i++)
        begin
            if (servedCount[i] != perSlave)
                reportMismatch("served count", 32'(perSlave), 32'(servedCount[i]));
        end

        $display("Responses delivered: %0d, acknowledged: %0d, errors: %0d",
                 deliveredCount, ackedCount, errorCount);
        if (errorCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: flist.f
writeResponsePkg.sv
responseIf.sv
responseArbiter.sv
responseCapture.sv
responseDelivery.sv
writeResponseInterconnect.sv
writeResponseTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the write response testbench with Verilator and runs it into sim.log
rm -f sim.log
verilator --binary --timing --top-module writeResponseTb -f flist.f -o writeResponseSim \
    && ./obj_dir/writeResponseSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
